//--- dv/pa_tb.sv
// P-A testbench: random and directed stimulus checked against a cycle reference model
`include "pa_cfg.svh"

module pa_tb;
	import pa_pkg::*;

	logic clk = 1'b0;
	logic rst_n;
	logic mwa, mwb, mwc, bwa, bwb, w_dt_;
	logic saa, sab, sb, sd, saryt, p16_, sca, scb, am1, apb, amb, ap1;
	logic baa, bab, bac, aa, ab;
	logic strob1, strob2_, as2, w_ac, w_ar, w_ic, arp1, arm4, icp1, off_;
	logic wx_, eat0, axy, ar_ad_, ic_ad_, barnb;
	word_t ir, ki, rdt_, kl, l;
	word_t ddt_, w, dad_;
	logic s0, carry_, j$, s_1, zs, exx_, at15_, exy_, wzi, arz, zga;

	// expected outputs and shadow registers
	word_t e_w, e_ddt, e_a, e_f, e_dad;
	logic e_s0, e_carry, e_j, e_s1, e_zs, e_exx, e_exy, e_at15, e_arz, e_zga, e_wzi;
	word_t m_ac, m_at, m_ar, m_ic;
	logic m_wzi;

	integer seed = 32'h565a;
	integer errors = 0;
	integer cycles = 0;
	string test_name = "reset";

	pa uut(.*);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= 1200) begin
			$display("timeout after %0d cycles, stimulus did not finish", cycles);
			$display("TB FAILED");
			$finish;
		end
	end

	function automatic word_t byte_mask(word_t v, logic lb, logic rb);
		return {v[0:7] & {8{lb}}, v[8:15] & {8{rb}}};
	endfunction

	function automatic void pa_model();
		word_t src, x, y, dad;
		logic [8:0] lo, hi;
		logic [3:0] code;
		logic sx, sext, c8;
		case ({mwa, mwb, mwc})
			`PA_WSRC_IR: src = ir;
			`PA_WSRC_KL: src = kl;
			`PA_WSRC_RDT: src = ~rdt_;
			`PA_WSRC_KI: src = ki;
			`PA_WSRC_AT: src = m_at;
			`PA_WSRC_AC: src = m_ac;
			`PA_WSRC_A: src = 16'h0000;
			default: src = 16'h0000;
		endcase
		case ({baa, bab, bac})
			`PA_ASRC_L: e_a = l;
			`PA_ASRC_T: e_a = {{10{ir[10]}}, ir[10:15]};
			`PA_ASRC_AR: e_a = m_ar;
			`PA_ASRC_IC: e_a = m_ic;
			default: e_a = 16'h0000;
		endcase
		e_a = byte_mask(e_a, aa, ab);
		if ({mwa, mwb, mwc} == `PA_WSRC_A)
			src = e_a;
		e_w = byte_mask(src, bwa, bwb);
		e_ddt = w_dt_ ? 16'hffff : ~e_w;
		e_exx = ~(ir[6] ? e_a[15] : e_a[0]);
		// 74181 with A = a bus and B = AC
		code = {sd, sb, sab, saa};
		case (code[1:0])
			2'd0: x = e_a;
			2'd1: x = e_a | m_ac;
			2'd2: x = e_a | ~m_ac;
			default: x = 16'hffff;
		endcase
		case (code[3:2])
			2'd0: y = 16'h0000;
			2'd1: y = e_a & ~m_ac;
			2'd2: y = e_a & m_ac;
			default: y = e_a;
		endcase
		lo = {1'b0, x[8:15]} + {1'b0, y[8:15]} + {8'd0, sca & ~p16_};
		c8 = scb & lo[8];
		hi = {1'b0, x[0:7]} + {1'b0, y[0:7]} + {8'd0, c8};
		case (code)
			4'd0: e_f = ~e_a;
			4'd1: e_f = ~(e_a | m_ac);
			4'd2: e_f = ~e_a & m_ac;
			4'd3: e_f = 16'h0000;
			4'd4: e_f = ~(e_a & m_ac);
			4'd5: e_f = ~m_ac;
			4'd6: e_f = e_a ^ m_ac;
			4'd7: e_f = e_a & ~m_ac;
			4'd8: e_f = ~e_a | m_ac;
			4'd9: e_f = ~(e_a ^ m_ac);
			4'd10: e_f = m_ac;
			4'd11: e_f = e_a & m_ac;
			4'd12: e_f = 16'hffff;
			4'd13: e_f = e_a | ~m_ac;
			4'd14: e_f = e_a | m_ac;
			default: e_f = e_a;
		endcase
		if (saryt)
			e_f = {hi[7:0], lo[7:0]};
		e_carry = ~hi[8];
		e_s0 = e_f[0];
		e_j = (e_f == 16'hffff);
		sx = e_a[0] ^ m_ac[0];
		sext = ~((am1 & ~e_a[0]) | (apb & sx) | (amb & ~sx) | (ap1 & e_a[0]));
		e_s1 = sext ^ e_carry;
		e_zs = !e_s1 && (e_f == 16'h0000);
		e_at15 = ~m_at[15];
		e_exy = ~(axy ? m_at[15] : e_a[0]);
		e_arz = (m_ar[0:7] != 8'h00);
		dad = (ar_ad_ ? 16'h0000 : m_ar) | (ic_ad_ ? 16'h0000 : m_ic);
		e_dad = ~dad;
		e_zga = (kl[1:15] == dad[1:15]) && (kl[0] == !barnb);
		e_wzi = m_wzi;
		// state after the coming edge
		if (w_ac && ((strob1 && !as2) || (!strob2_ && as2)))
			m_ac = e_w;
		if (!off_)
			m_ic = 16'h0000;
		else if (w_ic && ((strob1 && !as2) || (!strob2_ && as2)))
			m_ic = e_w;
		else if (icp1 && strob1)
			m_ic = m_ic + 16'd1;
		if (w_ar && ((strob1 && !as2) || (!strob2_ && as2)))
			m_ar = e_w;
		else if (arp1 && strob1 && !as2)
			m_ar = arm4 ? m_ar - `PA_AR_BACK : m_ar + 16'd1;
		if (strob1 && as2) begin
			m_at = e_f;
			m_wzi = e_zs;
		end else if (strob1 && !wx_)
			m_at = {eat0, m_at[0:14]};
	endfunction

	task automatic check_word(string what, word_t exp, word_t act);
		if (exp !== act) begin
			errors = errors + 1;
			$display("Mismatch %s %s expected %h actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic check_bit(string what, logic exp, logic act);
		if (exp !== act) begin
			errors = errors + 1;
			$display("Mismatch %s %s expected %b actual %b", test_name, what, exp, act);
		end
	endtask

	// compare just before each rising edge
	always begin
		@(posedge clk);
		#35;
		if (rst_n) begin
			pa_model();
			check_word("w", e_w, w);
			check_word("ddt_", e_ddt, ddt_);
			check_word("dad_", e_dad, dad_);
			check_bit("s0", e_s0, s0);
			check_bit("carry_", e_carry, carry_);
			check_bit("j$", e_j, j$);
			check_bit("s_1", e_s1, s_1);
			check_bit("zs", e_zs, zs);
			check_bit("exx_", e_exx, exx_);
			check_bit("exy_", e_exy, exy_);
			check_bit("at15_", e_at15, at15_);
			check_bit("arz", e_arz, arz);
			check_bit("zga", e_zga, zga);
			check_bit("wzi", e_wzi, wzi);
		end else begin
			// registers are cleared while reset is held
			m_ac = 16'h0000;
			m_at = 16'h0000;
			m_ar = 16'h0000;
			m_ic = 16'h0000;
			m_wzi = 1'b0;
		end
	end

	task automatic drive_random();
		integer r1, r2;
		r1 = $random(seed);
		r2 = $random(seed);
		{mwa, mwb, mwc, bwa, bwb, w_dt_, saa, sab, sb, sd, saryt, p16_} = r1[11:0];
		{sca, scb, am1, apb, amb, ap1, baa, bab, bac, aa, ab} = r1[22:12];
		{strob1, strob2_, as2, w_ac, w_ar, w_ic, arp1, arm4} = r2[7:0];
		{icp1, wx_, eat0, axy, ar_ad_, ic_ad_, barnb} = r2[14:8];
		off_ = (r2[18:16] != 3'd0);
		r1 = $random(seed);
		r2 = $random(seed);
		{ir, ki} = r1;
		{rdt_, kl} = r2;
		r1 = $random(seed);
		l = r1[15:0];
	endtask

	initial begin
		integer i, r, bitn;
		rst_n = 1'b0;
		drive_random();
		repeat (4) @(posedge clk);
		#5 rst_n = 1'b1;
		for (i = 0; i < 600; i = i + 1) begin
			@(posedge clk);
			#5;
			drive_random();
			if (i < 64) begin
				test_name = "w_bus";
				{w_dt_, bwa, bwb, mwa, mwb, mwc} = i[5:0];
			end else if (i < 128) begin
				test_name = "a_bus";
				{ir[6], aa, ab, baa, bab, bac} = i[5:0];
				// short argument negative in one half, positive in the other
				ir[10] = i[5];
				{mwa, mwb, mwc} = `PA_WSRC_A;
			end else if (i < 328) begin
				test_name = "alu";
			end else if (i < 424) begin
				test_name = "ac_at";
				w_ac = 1'b1;
			end else if (i < 520) begin
				test_name = "ar_ic";
				arp1 = 1'b1;
				icp1 = 1'b1;
			end else begin
				test_name = "address";
				strob1 = 1'b0;
				strob2_ = 1'b1;
				r = $random(seed);
				bitn = 1 + ((r & 32'h7fffffff) % 15);
				kl[0] = !barnb;
				kl[1:15] = (ar_ad_ ? 15'h0000 : m_ar[1:15]) |
					(ic_ad_ ? 15'h0000 : m_ic[1:15]);
				if (i % 3 == 1)
					kl[bitn] = ~kl[bitn];
				else if (i % 3 == 2)
					kl[0] = barnb;
			end
		end
		@(posedge clk);
		$display("run complete with %0d errors", errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

//--- hw/alu.sv
// ALU: 74181-style function unit with byte-split carry, sign extension and zero flags
module alu(
	alu_ctl_if.fn ctl,
	input  pa_pkg::word_t a,
	input  pa_pkg::word_t ac,
	output pa_pkg::word_t f,
	output logic s0,
	output logic carry_,
	output logic j$,
	output logic s_1,
	output logic zs
);
	import pa_pkg::*;

	word_t t1;
	word_t t2;
	logic cin;
	logic c8;
	logic [8:0] sum_lo;
	logic [8:0] sum_hi;
	logic sign_xor;
	logic sext;

	// per-bit terms of the 74181, t1 propagates and t2 generates
	assign t1 = a | (ac & {16{ctl.saa}}) | (~ac & {16{ctl.sab}});
	assign t2 = (a & ~ac & {16{ctl.sb}}) | (a & ac & {16{ctl.sd}});

	// carry into bit 15
	assign cin = ctl.sca & ~ctl.p16_;

	// right byte first, bits 8..15
	assign sum_lo = {1'b0, t1[8:15]} + {1'b0, t2[8:15]} + {8'd0, cin};

	// byte carry passes only with scb
	assign c8 = ctl.scb & sum_lo[8];
	assign sum_hi = {1'b0, t1[0:7]} + {1'b0, t2[0:7]} + {8'd0, c8};

	// logic mode is the inverted sum without carries
	assign f = ctl.saryt ? {sum_hi[7:0], sum_lo[7:0]} : ~(t1 ^ t2);

	assign carry_ = ~sum_hi[8];
	assign s0 = f[0];
	assign j$ = &f;

	// 17th bit for overflow and zero
	assign sign_xor = a[0] ^ ac[0];
	assign sext = ~((~a[0] & ctl.am1) | (sign_xor & ctl.apb) |
		(~sign_xor & ctl.amb) | (a[0] & ctl.ap1));
	assign s_1 = sext ^ carry_;

	assign zs = ~s_1 & (f == '0);

endmodule

//--- hw/alu_ctl_if.sv
// ALU control bundle: function select, carry controls and sign-extension selects
interface alu_ctl_if;

	// function select, 74181 order S0..S3
	logic saa;
	logic sab;
	logic sb;
	logic sd;
	// arithmetic mode and carries
	logic saryt;
	logic p16_;
	logic sca;
	logic scb;
	// sign extension for s_1
	logic am1;
	logic apb;
	logic amb;
	logic ap1;

	modport ctl(output saa, sab, sb, sd, saryt, p16_, sca, scb, am1, apb, amb, ap1);
	modport fn(input saa, sab, sb, sd, saryt, p16_, sca, scb, am1, apb, amb, ap1);

endinterface

//--- hw/bus_a.sv
// A bus: source select, short argument sign extension and the exx_ bit test
`include "pa_cfg.svh"

module bus_a(
	input  logic baa,
	input  logic bab,
	input  logic bac,
	input  logic aa,
	input  logic ab,
	input  pa_pkg::word_t l,
	input  pa_pkg::word_t ar,
	input  pa_pkg::word_t ic,
	input  pa_pkg::ir_t ir,
	output pa_pkg::word_t a,
	output logic exx_
);
	import pa_pkg::*;

	word_t src;
	word_t t_ext;

	// short argument widened with its sign bit
	assign t_ext = {{10{ir.sarg.t[0]}}, ir.sarg.t};

	always_comb begin
		case ({baa, bab, bac})
			`PA_ASRC_L:  src = l;
			`PA_ASRC_T:  src = t_ext;
			`PA_ASRC_AR: src = ar;
			`PA_ASRC_IC: src = ic;
			default:     src = '0;
		endcase
	end

	assign a = src & {{8{aa}}, {8{ab}}};

	// d picks the tested end of the word
	assign exx_ = ~(ir.norm.d ? a[15] : a[0]);

endmodule

//--- hw/bus_w.sv
// W bus: source select, byte masking and the inverted data-out drive
`include "pa_cfg.svh"

module bus_w(
	input  logic mwa,
	input  logic mwb,
	input  logic mwc,
	input  logic bwa,
	input  logic bwb,
	input  logic w_dt_,
	input  pa_pkg::word_t ir,
	input  pa_pkg::word_t kl,
	input  pa_pkg::word_t rdt_,
	input  pa_pkg::word_t ki,
	input  pa_pkg::word_t at,
	input  pa_pkg::word_t ac,
	input  pa_pkg::word_t a,
	output pa_pkg::word_t w,
	output pa_pkg::word_t ddt_
);
	import pa_pkg::*;

	word_t src;

	always_comb begin
		case ({mwa, mwb, mwc})
			`PA_WSRC_IR:  src = ir;
			`PA_WSRC_KL:  src = kl;
			// memory data arrives inverted
			`PA_WSRC_RDT: src = ~rdt_;
			`PA_WSRC_KI:  src = ki;
			`PA_WSRC_AT:  src = at;
			`PA_WSRC_AC:  src = ac;
			`PA_WSRC_A:   src = a;
			default:      src = '0;
		endcase
	end

	// bwa passes the left byte, bwb the right one
	assign w = src & {{8{bwa}}, {8{bwb}}};
	assign ddt_ = w_dt_ ? '1 : ~w;

endmodule

//--- hw/pa.sv
// P-A arithmetic unit: W and A buses, ALU and registers wired to plain ports
module pa(
	input  logic clk,
	input  logic rst_n,
	// W bus
	input  pa_pkg::word_t ir,
	input  pa_pkg::word_t ki,
	input  pa_pkg::word_t rdt_,
	input  pa_pkg::word_t kl,
	input  logic w_dt_,
	input  logic mwa, mwb, mwc,
	input  logic bwa, bwb,
	output pa_pkg::word_t ddt_,
	output pa_pkg::word_t w,
	// ALU
	input  logic saa, sab, sb, sd,
	input  logic saryt, p16_, sca, scb,
	input  logic am1, apb, amb, ap1,
	output logic s0,
	output logic carry_,
	output logic j$,
	output logic s_1,
	output logic zs,
	// A bus
	input  pa_pkg::word_t l,
	input  logic baa, bab, bac,
	input  logic aa, ab,
	output logic exx_,
	// registers and strobes
	input  logic strob1, strob2_, as2,
	input  logic w_ac, w_ar, w_ic,
	input  logic arp1, arm4, icp1, off_,
	input  logic wx_, eat0, axy,
	output logic at15_,
	output logic exy_,
	output logic wzi,
	output logic arz,
	// address
	input  logic ar_ad_, ic_ad_, barnb,
	output pa_pkg::word_t dad_,
	output logic zga
);
	import pa_pkg::*;

	word_t a;
	word_t f;
	word_t ac;
	word_t at;
	word_t ar;
	word_t ic;

	alu_ctl_if ctl();

	assign ctl.saa = saa;
	assign ctl.sab = sab;
	assign ctl.sb = sb;
	assign ctl.sd = sd;
	assign ctl.saryt = saryt;
	assign ctl.p16_ = p16_;
	assign ctl.sca = sca;
	assign ctl.scb = scb;
	assign ctl.am1 = am1;
	assign ctl.apb = apb;
	assign ctl.amb = amb;
	assign ctl.ap1 = ap1;

	bus_w u_bus_w(.*);

	// instruction word seen through its decode views
	bus_a u_bus_a(.ir(ir), .*);

	alu u_alu(.*);

	pa_regs u_regs(.*);

endmodule

//--- hw/pa_cfg.svh
// P-A configuration: bus source select codes and the AR step size
`ifndef PA_CFG_SVH
`define PA_CFG_SVH

// W bus sources on {mwa, mwb, mwc}, code 7 reads zero
`define PA_WSRC_IR  3'd0
`define PA_WSRC_KL  3'd1
`define PA_WSRC_RDT 3'd2
`define PA_WSRC_KI  3'd3
`define PA_WSRC_AT  3'd4
`define PA_WSRC_AC  3'd5
`define PA_WSRC_A   3'd6

// A bus sources on {baa, bab, bac}, codes 4..7 read zero
`define PA_ASRC_L  3'd0
`define PA_ASRC_T  3'd1
`define PA_ASRC_AR 3'd2
`define PA_ASRC_IC 3'd3

// backward step of AR
`define PA_AR_BACK 16'd4

`endif

//--- hw/pa_pkg.sv
// P-A shared types: the data word and the two decodings of the instruction word
package pa_pkg;

	// bit 0 is the most significant bit
	typedef logic [0:15] word_t;

	// register form of the instruction
	typedef struct packed {
		logic [0:5] op;
		logic       d;
		logic [0:2] a;
		logic [0:2] b;
		logic [0:2] c;
	} ir_norm_t;

	// short argument form, t is signed
	typedef struct packed {
		logic [0:5] op;
		logic       d;
		logic [0:2] a;
		logic [0:5] t;
	} ir_short_t;

	typedef union packed {
		ir_norm_t  norm;
		ir_short_t sarg;
	} ir_t;

endpackage

//--- hw/pa_regs.sv
// P-A registers: AC, AT, AR, IC and WZI with strobe enables, address drive and compare
`include "pa_cfg.svh"

module pa_regs(
	input  logic clk,
	input  logic rst_n,
	input  logic strob1,
	input  logic strob2_,
	input  logic as2,
	input  logic w_ac,
	input  logic w_ar,
	input  logic w_ic,
	input  logic arp1,
	input  logic arm4,
	input  logic icp1,
	input  logic off_,
	input  logic wx_,
	input  logic eat0,
	input  logic axy,
	input  logic ar_ad_,
	input  logic ic_ad_,
	input  logic barnb,
	input  logic zs,
	input  pa_pkg::word_t w,
	input  pa_pkg::word_t f,
	input  pa_pkg::word_t a,
	input  pa_pkg::word_t kl,
	output pa_pkg::word_t ac,
	output pa_pkg::word_t at,
	output pa_pkg::word_t ar,
	output pa_pkg::word_t ic,
	output pa_pkg::word_t dad_,
	output logic wzi,
	output logic at15_,
	output logic exy_,
	output logic arz,
	output logic zga
);
	import pa_pkg::*;

	logic w_any;
	word_t dad;

	// strob1 in the first phase, strob2 in the second
	assign w_any = (strob1 & ~as2) | (~strob2_ & as2);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ac <= '0;
			at <= '0;
			wzi <= 1'b0;
		end else begin
			if (w_ac && w_any)
				ac <= w;
			if (strob1 && as2)
				at <= f;
			else if (strob1 && !wx_)
				at <= {eat0, at[0:14]};
			if (strob1 && as2)
				wzi <= zs;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ar <= '0;
		else if (w_ar && w_any)
			ar <= w;
		else if (arp1 && strob1 && !as2)
			ar <= arm4 ? ar - `PA_AR_BACK : ar + 16'd1;
	end

	// off_ clears IC ahead of load and count
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ic <= '0;
		else if (!off_)
			ic <= '0;
		else if (w_ic && w_any)
			ic <= w;
		else if (icp1 && strob1)
			ic <= ic + 16'd1;
	end

	assign at15_ = ~at[15];
	assign exy_ = ~(axy ? at[15] : a[0]);
	assign arz = |ar[0:7];

	// address drive, either register or both ORed
	assign dad = (ar & {16{~ar_ad_}}) | (ic & {16{~ic_ad_}});
	assign dad_ = ~dad;

	// bit 0 of kl compares against the block select
	assign zga = (kl[1:15] == dad[1:15]) && (kl[0] == ~barnb);

endmodule

//--- pa.f
+incdir+hw
hw/pa_pkg.sv
hw/alu_ctl_if.sv
hw/bus_w.sv
hw/bus_a.sv
hw/alu.sv
hw/pa_regs.sv
hw/pa.sv
dv/pa_tb.sv

//--- run_sim.sh
#!/bin/bash
# build and run the P-A testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module pa_tb -f pa.f -o pa_sim \
	&& ./obj_dir/pa_sim > sim.log 2>&1 \
	|| echo "build or run did not complete" >> sim.log
cat sim.log
if grep -q "TB FAILED" sim.log || ! grep -q "TB PASSED" sim.log; then
	exit 1
fi
exit 0
